//--- hw/ifu_consts.svh
// instruction fetch constants: bus widths, boot offset, debug entries and trap vector layout
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// address and data width of the fetch bus
`define IFU_XLEN 32

// one compressed parcel
`define IFU_HW 16

// low byte of the boot PC, upper bits come from boot_addr_i
`define IFU_BOOT_OFS 8'h80

// debug module entry points
`define IFU_DM_HALT_ADDR 32'h1A110800
`define IFU_DM_EXC_ADDR 32'h1A110808

// interrupt id width and mtvec base alignment for vectored mode
`define IFU_IRQ_ID_W 5
`define IFU_VEC_ALIGN 8

`endif

//--- hw/ifu_pkg.sv
// instruction fetch types: PC select encodings and the two views of a fetched word
`include "ifu_consts.svh"

package ifu_pkg;

  ////////////////////////////////////////
  // redirect selects
  ////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // trap vector source when PC_EXC is selected
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  ////////////////////////////////////////
  // fetched word
  ////////////////////////////////////////

  // a word is either one full instruction or two 16-bit parcels
  typedef union packed {
    logic [`IFU_XLEN-1:0] word;
    struct packed {
      logic [`IFU_HW-1:0] hi;
      logic [`IFU_HW-1:0] lo;
    } half;
  } fetch_word_u;

endpackage

//--- hw/ifu_pc_select.sv
// next fetch address mux with trap vector selection and mtvec init on boot
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_pc_select import ifu_pkg::*; (
  input  logic                     pc_set_i,
  input  pc_sel_e                  pc_mux_i,
  input  exc_pc_sel_e              exc_pc_mux_i,
  input  logic [`IFU_IRQ_ID_W-1:0] exc_irq_id_i,
  input  logic [`IFU_XLEN-1:0]     boot_addr_i,
  input  logic [`IFU_XLEN-1:0]     branch_target_i,
  input  logic [`IFU_XLEN-1:0]     csr_mepc_i,
  input  logic [`IFU_XLEN-1:0]     csr_depc_i,
  input  logic [`IFU_XLEN-1:0]     csr_mtvec_i,
  output logic [`IFU_XLEN-1:0]     fetch_addr_n_o,
  output logic                     csr_mtvec_init_o
);

  logic [`IFU_XLEN-1:0] vec_base;
  logic [`IFU_XLEN-1:0] word_base;
  logic [`IFU_XLEN-1:0] irq_ofs;
  logic [`IFU_XLEN-1:0] exc_pc;

  // vectored mode base, low bits forced to zero
  assign vec_base  = {csr_mtvec_i[`IFU_XLEN-1:`IFU_VEC_ALIGN], {`IFU_VEC_ALIGN{1'b0}}};
  // direct mode only drops the mode bits
  assign word_base = {csr_mtvec_i[`IFU_XLEN-1:2], 2'b00};
  // one 4-byte slot per interrupt id
  assign irq_ofs   = {{(`IFU_XLEN-`IFU_IRQ_ID_W-2){1'b0}}, exc_irq_id_i, 2'b00};

  ////////////////////////////////////////
  // trap vector
  ////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = csr_mtvec_i[0] ? vec_base : word_base;
      // only interrupts take the per-id slot in vectored mode
      EXC_PC_IRQ:     exc_pc = csr_mtvec_i[0] ? (vec_base + irq_ofs) : word_base;
      EXC_PC_DBD:     exc_pc = `IFU_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IFU_DM_EXC_ADDR;
      default:        exc_pc = word_base;
    endcase
  end

  ////////////////////////////////////////
  // fetch address
  ////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = {boot_addr_i[`IFU_XLEN-1:8], `IFU_BOOT_OFS};
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap handler
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      // return from debug mode
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      default: fetch_addr_n_o = {boot_addr_i[`IFU_XLEN-1:8], `IFU_BOOT_OFS};
    endcase
  end

  // CSR file loads mtvec from the boot address on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

//--- hw/ifu_fetch_buffer.sv
// word fetch over req/gnt/rvalid with halfword realignment into 16/32-bit instructions
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_fetch_buffer import ifu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 pc_set_i,
  input  logic [`IFU_XLEN-1:0] fetch_addr_n_i,
  input  logic                 fetch_ready_i,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  logic                 instr_err_i,
  input  logic [`IFU_XLEN-1:0] instr_rdata_i,
  output logic                 instr_req_o,
  output logic [`IFU_XLEN-1:0] instr_addr_o,
  output logic                 fetch_valid_o,
  output fetch_word_u          fetch_rdata_o,
  output logic [`IFU_XLEN-1:0] fetch_addr_o,
  output logic                 fetch_err_o,
  output logic                 busy_o
);

  // bus transaction state, one outstanding at most
  logic                 req_q, req_d;
  logic                 pending_q, pending_d;
  logic                 drop_q, drop_d;
  logic                 bus_free;
  logic                 launch;
  logic [`IFU_XLEN-1:0] req_addr_q;

  // next word to fetch and PC of the instruction in front
  logic [`IFU_XLEN-1:0] addr_q, addr_d;
  logic [`IFU_XLEN-1:0] pc_q, pc_d;

  // one-word store, plus the low half of a straddling instruction
  fetch_word_u          word_q, word_d;
  logic                 word_vld_q, word_vld_d;
  logic                 word_err_q, word_err_d;
  logic [`IFU_HW-1:0]   half_q, half_d;
  logic                 half_vld_q, half_vld_d;
  logic                 err_stop_q, err_stop_d;

  logic [`IFU_HW-1:0]   parcel;
  logic                 parcel_c;
  logic                 split;
  logic                 xfer;
  logic                 rx;

  ////////////////////////////////////////
  // instruction output
  ////////////////////////////////////////

  // first parcel of the instruction at pc_q
  always_comb begin
    if (half_vld_q) begin
      parcel = half_q;
    end else if (pc_q[1]) begin
      parcel = word_q.half.hi;
    end else begin
      parcel = word_q.half.lo;
    end
  end

  // low bits other than 11 mark a compressed parcel
  assign parcel_c = (parcel[1:0] != 2'b11);

  // full instruction at offset 2, park its low half and fetch the next word
  // an errored word is handed out as is, its parcels cannot be trusted
  assign split = ~half_vld_q & word_vld_q & pc_q[1] & ~parcel_c & ~word_err_q;

  // a straddle needs both halves, so word_vld_q covers both cases
  assign fetch_valid_o = word_vld_q & ~split;
  assign fetch_addr_o  = pc_q;
  assign fetch_err_o   = word_err_q;

  always_comb begin
    fetch_rdata_o = word_q;
    if (half_vld_q) begin
      // joined instruction, upper half comes from the newer word
      fetch_rdata_o.half.lo = half_q;
      fetch_rdata_o.half.hi = word_q.half.lo;
    end else if (pc_q[1]) begin
      fetch_rdata_o.half.lo = word_q.half.hi;
      fetch_rdata_o.half.hi = '0;
    end
  end

  assign xfer = fetch_valid_o & fetch_ready_i;
  // accepted response, stale ones are dropped
  assign rx   = instr_rvalid_i & ~drop_q & ~pc_set_i;

  ////////////////////////////////////////
  // store and PC update
  ////////////////////////////////////////

  always_comb begin
    pc_d       = pc_q;
    addr_d     = addr_q;
    word_d     = word_q;
    word_vld_d = word_vld_q;
    word_err_d = word_err_q;
    half_d     = half_q;
    half_vld_d = half_vld_q;
    err_stop_d = err_stop_q;
    drop_d     = drop_q;
    if (pc_set_i) begin
      // redirect flushes everything queued
      pc_d       = {fetch_addr_n_i[`IFU_XLEN-1:1], 1'b0};
      addr_d     = {fetch_addr_n_i[`IFU_XLEN-1:2], 2'b00};
      word_vld_d = 1'b0;
      half_vld_d = 1'b0;
      err_stop_d = 1'b0;
      // anything still on the bus belongs to the old stream
      drop_d     = req_q | (pending_q & ~instr_rvalid_i);
    end else begin
      if (instr_rvalid_i) begin
        drop_d = 1'b0;
      end
      if (xfer) begin
        pc_d       = pc_q + (parcel_c ? 32'd2 : 32'd4);
        half_vld_d = 1'b0;
        // word is used up unless a second parcel remains in it
        if (~half_vld_q & (pc_q[1] | ~parcel_c)) begin
          word_vld_d = 1'b0;
        end
      end else if (split) begin
        half_d     = word_q.half.hi;
        half_vld_d = 1'b1;
        word_vld_d = 1'b0;
      end
      // rx only happens with an empty store
      if (rx) begin
        word_d     = instr_rdata_i;
        word_vld_d = 1'b1;
        word_err_d = instr_err_i;
        addr_d     = addr_q + 32'd4;
        // no prefetch past a bus error
        err_stop_d = err_stop_q | instr_err_i;
      end
    end
  end

  ////////////////////////////////////////
  // bus requests
  ////////////////////////////////////////

  // bus idle from next cycle on
  assign bus_free = ~req_q & (~pending_q | instr_rvalid_i);
  // only fetch into an empty store
  assign launch   = bus_free & req_i & ~err_stop_d & ~word_vld_d;

  assign req_d     = (req_q & ~instr_gnt_i) | launch;
  assign pending_d = (pending_q & ~instr_rvalid_i) | (req_q & instr_gnt_i);

  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;
  assign busy_o       = req_q | pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q      <= 1'b0;
      pending_q  <= 1'b0;
      drop_q     <= 1'b0;
      word_vld_q <= 1'b0;
      half_vld_q <= 1'b0;
      err_stop_q <= 1'b0;
    end else begin
      req_q      <= req_d;
      pending_q  <= pending_d;
      drop_q     <= drop_d;
      word_vld_q <= word_vld_d;
      half_vld_q <= half_vld_d;
      err_stop_q <= err_stop_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_q       <= pc_d;
    addr_q     <= addr_d;
    word_q     <= word_d;
    word_err_q <= word_err_d;
    half_q     <= half_d;
    // address is frozen for the whole request
    if (launch) begin
      req_addr_q <= addr_d;
    end
  end

endmodule

//--- hw/ifu_id_reg.sv
// compressed classification and the IF-ID pipeline register with valid and new flags
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_id_reg import ifu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_valid_i,
  input  fetch_word_u          fetch_rdata_i,
  input  logic [`IFU_XLEN-1:0] fetch_addr_i,
  input  logic                 fetch_err_i,
  input  logic                 id_in_ready_i,
  input  logic                 pc_set_i,
  input  logic                 instr_valid_clear_i,
  output logic                 fetch_ready_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output logic [`IFU_XLEN-1:0] instr_rdata_id_o,
  output logic                 instr_is_compressed_id_o,
  output logic                 illegal_c_insn_id_o,
  output logic                 instr_fetch_err_o,
  output logic [`IFU_XLEN-1:0] pc_id_o
);

  logic                 xfer;
  logic                 is_c;
  logic                 illegal_c;
  logic [`IFU_XLEN-1:0] instr_word;
  logic                 valid_q, valid_d;
  logic                 new_q;

  assign fetch_ready_o = id_in_ready_i;
  assign xfer          = fetch_valid_i & id_in_ready_i;

  ////////////////////////////////////////
  // classification
  ////////////////////////////////////////

  assign is_c      = (fetch_rdata_i.word[1:0] != 2'b11);
  // all-zero parcel is the defined illegal compressed encoding
  assign illegal_c = is_c & (fetch_rdata_i.word[`IFU_HW-1:0] == '0);

  // ID gets the raw parcel, upper half cleared for compressed
  assign instr_word = is_c ?
                      {{(`IFU_XLEN-`IFU_HW){1'b0}}, fetch_rdata_i.word[`IFU_HW-1:0]} :
                      fetch_rdata_i.word;

  ////////////////////////////////////////
  // valid and new flags
  ////////////////////////////////////////

  // redirect squashes the entry arriving with it
  // valid holds until ID clears it
  assign valid_d = (xfer & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= xfer;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // pipeline payload, loaded on every transfer
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      instr_rdata_id_o         <= instr_word;
      instr_is_compressed_id_o <= is_c;
      illegal_c_insn_id_o      <= illegal_c;
      instr_fetch_err_o        <= fetch_err_i;
      pc_id_o                  <= fetch_addr_i;
    end
  end

endmodule

//--- hw/ifu_pc_check.sv
// sequential PC checker, flags ID entries that do not follow the previous one by 2 or 4
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_pc_check (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 instr_new_id_i,
  input  logic                 pc_set_i,
  input  logic                 instr_is_compressed_id_i,
  input  logic [`IFU_XLEN-1:0] pc_id_i,
  output logic                 pc_mismatch_alert_o
);

  logic                 armed_q, armed_d;
  logic                 set_q;
  logic [`IFU_XLEN-1:0] next_pc_q;

  // entry right after a redirect cycle was squashed and must not arm
  // error entries halt fetch, so only a redirect follows them
  assign armed_d = ~pc_set_i & (armed_q | (instr_new_id_i & ~set_q));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q <= 1'b0;
      set_q   <= 1'b0;
    end else begin
      armed_q <= armed_d;
      set_q   <= pc_set_i;
    end
  end

  // expected PC of the following entry
  always_ff @(posedge clk_i) begin
    if (instr_new_id_i) begin
      next_pc_q <= pc_id_i + (instr_is_compressed_id_i ? 32'd2 : 32'd4);
    end
  end

  assign pc_mismatch_alert_o = armed_q & instr_new_id_i & (pc_id_i != next_pc_q);

endmodule

//--- hw/ifu_top.sv
// instruction fetch stage top: PC select, fetch buffer, IF-ID register and PC checker
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_top import ifu_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic [`IFU_XLEN-1:0]     boot_addr_i,
  // redirect control
  input  logic                     pc_set_i,
  input  pc_sel_e                  pc_mux_i,
  input  exc_pc_sel_e              exc_pc_mux_i,
  input  logic [`IFU_IRQ_ID_W-1:0] exc_irq_id_i,
  input  logic [`IFU_XLEN-1:0]     branch_target_i,
  input  logic [`IFU_XLEN-1:0]     csr_mepc_i,
  input  logic [`IFU_XLEN-1:0]     csr_depc_i,
  input  logic [`IFU_XLEN-1:0]     csr_mtvec_i,
  output logic                     csr_mtvec_init_o,
  // instruction bus
  output logic                     instr_req_o,
  output logic [`IFU_XLEN-1:0]     instr_addr_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [`IFU_XLEN-1:0]     instr_rdata_i,
  input  logic                     instr_err_i,
  // ID stage
  input  logic                     id_in_ready_i,
  input  logic                     instr_valid_clear_i,
  output logic                     instr_valid_id_o,
  output logic                     instr_new_id_o,
  output logic [`IFU_XLEN-1:0]     instr_rdata_id_o,
  output logic                     instr_is_compressed_id_o,
  output logic                     illegal_c_insn_id_o,
  output logic                     instr_fetch_err_o,
  output logic [`IFU_XLEN-1:0]     pc_id_o,
  output logic                     pc_mismatch_alert_o,
  output logic                     if_busy_o
);

  logic [`IFU_XLEN-1:0] fetch_addr_n;
  logic                 fetch_valid;
  logic                 fetch_ready;
  fetch_word_u          fetch_rdata;
  logic [`IFU_XLEN-1:0] fetch_addr;
  logic                 fetch_err;

  ifu_pc_select u_pc_select (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_irq_id_i     (exc_irq_id_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ifu_fetch_buffer u_fetch_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fetch_addr_n_i (fetch_addr_n),
    .fetch_ready_i  (fetch_ready),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_err_i    (instr_err_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_addr_o   (fetch_addr),
    .fetch_err_o    (fetch_err),
    .busy_o         (if_busy_o)
  );

  ifu_id_reg u_id_reg (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .fetch_valid_i            (fetch_valid),
    .fetch_rdata_i            (fetch_rdata),
    .fetch_addr_i             (fetch_addr),
    .fetch_err_i              (fetch_err),
    .id_in_ready_i            (id_in_ready_i),
    .pc_set_i                 (pc_set_i),
    .instr_valid_clear_i      (instr_valid_clear_i),
    .fetch_ready_o            (fetch_ready),
    .instr_valid_id_o         (instr_valid_id_o),
    .instr_new_id_o           (instr_new_id_o),
    .instr_rdata_id_o         (instr_rdata_id_o),
    .instr_is_compressed_id_o (instr_is_compressed_id_o),
    .illegal_c_insn_id_o      (illegal_c_insn_id_o),
    .instr_fetch_err_o        (instr_fetch_err_o),
    .pc_id_o                  (pc_id_o)
  );

  ifu_pc_check u_pc_check (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .instr_new_id_i           (instr_new_id_o),
    .pc_set_i                 (pc_set_i),
    .instr_is_compressed_id_i (instr_is_compressed_id_o),
    .pc_id_i                  (pc_id_o),
    .pc_mismatch_alert_o      (pc_mismatch_alert_o)
  );

endmodule

//--- testbench/ifu_tb_clk.sv
// testbench clock source, free running with an 8 ns period
`timescale 1ns/100ps

module ifu_tb_clk (
  output logic clk_o
);

  // half period of 4 ns
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

endmodule

//--- testbench/ifu_top_chk.sv
// bound checker for the fetch stage covering redirect targets, fetched data, bus and ID rules
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_top_chk import ifu_pkg::*; (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     pc_set_i,
  input pc_sel_e                  pc_mux_i,
  input exc_pc_sel_e              exc_pc_mux_i,
  input logic [`IFU_IRQ_ID_W-1:0] exc_irq_id_i,
  input logic [`IFU_XLEN-1:0]     boot_addr_i,
  input logic [`IFU_XLEN-1:0]     branch_target_i,
  input logic [`IFU_XLEN-1:0]     csr_mepc_i,
  input logic [`IFU_XLEN-1:0]     csr_depc_i,
  input logic [`IFU_XLEN-1:0]     csr_mtvec_i,
  input logic                     csr_mtvec_init_o,
  input logic                     instr_req_o,
  input logic [`IFU_XLEN-1:0]     instr_addr_o,
  input logic                     instr_gnt_i,
  input logic                     instr_rvalid_i,
  input logic                     instr_valid_clear_i,
  input logic                     instr_valid_id_o,
  input logic                     instr_new_id_o,
  input logic [`IFU_XLEN-1:0]     instr_rdata_id_o,
  input logic                     instr_is_compressed_id_o,
  input logic                     illegal_c_insn_id_o,
  input logic                     instr_fetch_err_o,
  input logic [`IFU_XLEN-1:0]     pc_id_o,
  input logic                     pc_mismatch_alert_o,
  input logic                     if_busy_o
);

  // words from here upward answer with a bus error as in the memory model
  localparam logic [31:0] ERR_BASE = 32'h0003_8000;

  int          err_cnt = 0;
  logic        first_q;
  logic        set_q;
  logic        out_q;
  logic [31:0] first_pc_q;
  logic [15:0] lo_exp;
  logic [15:0] hi_exp;
  logic        c_exp;
  logic [31:0] rdata_exp;
  logic        touch_err;

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////

  // memory halfword is address bits 17:4 over a code picked by bits 3:2
  function automatic logic [15:0] mem_half(input logic [31:0] a);
    logic [1:0] code;
    case (a[3:2])
      2'd1:    code = 2'b01;
      2'd3:    code = 2'b00;
      default: code = 2'b11;
    endcase
    return {a[17:4], code};
  endfunction

  // redirect target from the selects and CSR values
  function automatic logic [31:0] target_pc(input pc_sel_e sel, input exc_pc_sel_e esel,
                                            input logic [4:0] irq, input logic [31:0] boot,
                                            input logic [31:0] br, input logic [31:0] mepc,
                                            input logic [31:0] depc, input logic [31:0] mtvec);
    logic [31:0] base;
    logic [31:0] pc;
    // vectored mode sits on a 256 byte boundary and direct mode on a word
    base = mtvec[0] ? (mtvec & 32'hFFFF_FF00) : (mtvec & 32'hFFFF_FFFC);
    case (sel)
      PC_BOOT: pc = (boot & 32'hFFFF_FF00) | 32'(`IFU_BOOT_OFS);
      PC_JUMP: pc = br;
      PC_ERET: pc = mepc;
      PC_DRET: pc = depc;
      default: begin
        case (esel)
          EXC_PC_DBD:     pc = `IFU_DM_HALT_ADDR;
          EXC_PC_DBG_EXC: pc = `IFU_DM_EXC_ADDR;
          EXC_PC_IRQ:     pc = mtvec[0] ? (base + irq * 32'd4) : base;
          default:        pc = base;
        endcase
      end
    endcase
    // fetch works on halfwords
    return pc & ~32'd1;
  endfunction

  ////////////////////////////////////////
  // tracking
  ////////////////////////////////////////

  // track the first entry after a redirect and skip the squashed one right behind it
  // a granted request stays outstanding until its response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= 1'b0;
      set_q   <= 1'b0;
      out_q   <= 1'b0;
    end else begin
      set_q <= pc_set_i;
      out_q <= (out_q && !instr_rvalid_i) || (instr_req_o && instr_gnt_i);
      if (pc_set_i) begin
        first_q <= 1'b1;
      end else if (instr_new_id_o && !set_q) begin
        first_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pc_set_i) begin
      first_pc_q <= target_pc(pc_mux_i, exc_pc_mux_i, exc_irq_id_i, boot_addr_i,
                              branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i);
    end
  end

  // expected ID contents for the entry at pc_id_o
  always_comb begin
    lo_exp    = mem_half(pc_id_o);
    hi_exp    = mem_half(pc_id_o + 32'd2);
    c_exp     = (lo_exp[1:0] != 2'b11);
    rdata_exp = c_exp ? {16'h0000, lo_exp} : {hi_exp, lo_exp};
    // own word or the next one for a full instruction
    touch_err = ((pc_id_o & ~32'd3) >= ERR_BASE) ||
                (!c_exp && (((pc_id_o + 32'd2) & ~32'd3) >= ERR_BASE));
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  mtvec_init_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == PC_BOOT))
    else begin
      $error("[FAIL] mtvec_init expected %b actual %b",
             $sampled(pc_set_i && pc_mux_i == PC_BOOT), $sampled(csr_mtvec_init_o));
      err_cnt = err_cnt + 1;
    end

  first_pc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o && !set_q && first_q |-> pc_id_o == first_pc_q)
    else begin
      $error("[FAIL] redirect_pc expected %h actual %h",
             $sampled(first_pc_q), $sampled(pc_id_o));
      err_cnt = err_cnt + 1;
    end

  // each redirect delivers its first entry before the next redirect
  progress_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i && first_q |-> instr_new_id_o && !set_q)
    else begin
      $error("no instruction reached ID between two redirects");
      err_cnt = err_cnt + 1;
    end

  entry_data_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o && !touch_err |-> instr_rdata_id_o == rdata_exp &&
    instr_is_compressed_id_o == c_exp && !instr_fetch_err_o &&
    illegal_c_insn_id_o == (c_exp && lo_exp == 16'h0000))
    else begin
      $error("[FAIL] entry_data pc %h expected %h c%b actual %h c%b ill%b err%b",
             $sampled(pc_id_o), $sampled(rdata_exp), $sampled(c_exp),
             $sampled(instr_rdata_id_o), $sampled(instr_is_compressed_id_o),
             $sampled(illegal_c_insn_id_o), $sampled(instr_fetch_err_o));
      err_cnt = err_cnt + 1;
    end

  entry_err_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o && touch_err |-> instr_fetch_err_o)
    else begin
      $error("[FAIL] entry_err pc %h expected 1 actual %b",
             $sampled(pc_id_o), $sampled(instr_fetch_err_o));
      err_cnt = err_cnt + 1;
    end

  addr_align_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else begin
      $error("[FAIL] addr_align expected 00 actual %b", $sampled(instr_addr_o[1:0]));
      err_cnt = err_cnt + 1;
    end

  // a waiting request keeps its address until granted
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      $error("request was withdrawn or its address changed before the grant");
      err_cnt = err_cnt + 1;
    end

  // busy while a request waits for grant or a response is still due
  busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    if_busy_o == (instr_req_o || out_q))
    else begin
      $error("[FAIL] if_busy expected %b actual %b",
             $sampled(instr_req_o || out_q), $sampled(if_busy_o));
      err_cnt = err_cnt + 1;
    end

  valid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_id_o && !instr_valid_clear_i && !pc_set_i |=> instr_valid_id_o)
    else begin
      $error("ID valid dropped without a clear or a redirect");
      err_cnt = err_cnt + 1;
    end

  no_alert_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pc_mismatch_alert_o)
    else begin
      $error("[FAIL] pc_alert expected 0 actual 1 at pc %h", $sampled(pc_id_o));
      err_cnt = err_cnt + 1;
    end

endmodule

//--- testbench/ifu_tb.sv
// testbench for the fetch stage: bus memory model, random ID handshake and redirects
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_tb import ifu_pkg::*;;

  // words from here upward answer with a bus error
  localparam logic [31:0] ERR_BASE = 32'h0003_8000;
  // 40 redirects of about 60 cycles, boot, directed jump and drain on top
  localparam int TIMEOUT_CYCLES = 4000;

  logic clk_i;
  logic rst_ni;
  logic req_i;
  logic [`IFU_XLEN-1:0] boot_addr_i;
  logic pc_set_i;
  pc_sel_e pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  logic [`IFU_IRQ_ID_W-1:0] exc_irq_id_i;
  logic [`IFU_XLEN-1:0] branch_target_i;
  logic [`IFU_XLEN-1:0] csr_mepc_i;
  logic [`IFU_XLEN-1:0] csr_depc_i;
  logic [`IFU_XLEN-1:0] csr_mtvec_i;
  logic csr_mtvec_init_o;
  logic instr_req_o;
  logic [`IFU_XLEN-1:0] instr_addr_o;
  logic instr_gnt_i;
  logic instr_rvalid_i;
  logic [`IFU_XLEN-1:0] instr_rdata_i;
  logic instr_err_i;
  logic id_in_ready_i;
  logic instr_valid_clear_i;
  logic instr_valid_id_o;
  logic instr_new_id_o;
  logic [`IFU_XLEN-1:0] instr_rdata_id_o;
  logic instr_is_compressed_id_o;
  logic illegal_c_insn_id_o;
  logic instr_fetch_err_o;
  logic [`IFU_XLEN-1:0] pc_id_o;
  logic pc_mismatch_alert_o;
  logic if_busy_o;

  // memory model and random source state
  logic [31:0] lfsr = 32'h88700e29;
  logic        rsp_pend;
  int          rsp_wait;
  logic [31:0] rsp_addr;
  int          cycle_cnt;

  ifu_tb_clk u_clk (.clk_o(clk_i));

  ifu_top u_ifu_top (.*);

  bind ifu_top ifu_top_chk u_chk (.*);

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // code from address bits 3:2 under address bits 17:4
  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [1:0] code;
    case (a[3:2])
      2'd0:    code = 2'b11;
      2'd1:    code = 2'b01;
      2'd2:    code = 2'b11;
      default: code = 2'b00;
    endcase
    return {a[17:4], code};
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] a);
    return {half_at(a + 32'd2), half_at(a)};
  endfunction

  // one clock of stimulus, everything changes on the falling edge
  task automatic step_cycle();
    logic [31:0] r;
    @(negedge clk_i);
    pc_set_i       = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    if (rsp_pend) begin
      if (rsp_wait == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = word_at(rsp_addr);
        instr_err_i    = (rsp_addr >= ERR_BASE);
        rsp_pend       = 1'b0;
      end else begin
        rsp_wait = rsp_wait - 1;
      end
    end else if (instr_req_o && take_bits(1) == 32'd1) begin
      // grant, response 0 to 3 idle cycles later
      instr_gnt_i = 1'b1;
      rsp_addr    = instr_addr_o;
      rsp_wait    = take_bits(2);
      rsp_pend    = 1'b1;
    end
    r                   = take_bits(3);
    id_in_ready_i       = (r[1:0] != 2'b00);
    instr_valid_clear_i = r[2];
  endtask

  task automatic run_cycles(input int n);
    repeat (n) step_cycle();
  endtask

  task automatic issue_redirect(input pc_sel_e sel);
    step_cycle();
    pc_set_i = 1'b1;
    pc_mux_i = sel;
  endtask

  // random select, vector mode, interrupt id and targets below bit 18
  task automatic random_redirect();
    logic [31:0] r;
    r               = take_bits(2);
    exc_pc_mux_i    = exc_pc_sel_e'(r[1:0]);
    r               = take_bits(5);
    exc_irq_id_i    = r[4:0];
    branch_target_i = take_bits(17) << 1;
    csr_mepc_i      = take_bits(17) << 1;
    csr_depc_i      = take_bits(17) << 1;
    csr_mtvec_i     = take_bits(18);
    r               = take_bits(3) % 5;
    issue_redirect(pc_sel_e'(r[2:0]));
  endtask

  ////////////////////////////////////////
  // failure watch and timeout
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (u_ifu_top.u_chk.err_cnt != 0) begin
      $display("Done: errors found");
      $fatal(1, "checker assertion failed, run stopped");
    end else if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Done: errors found");
      $fatal(1, "timeout after %0d cycles, fetch did not go idle", TIMEOUT_CYCLES);
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    cycle_cnt           = 0;
    rsp_pend            = 1'b0;
    rsp_wait            = 0;
    rsp_addr            = '0;
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    boot_addr_i         = 32'h0000_1000;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_irq_id_i        = '0;
    branch_target_i     = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    csr_mtvec_i         = '0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_err_i         = 1'b0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    // fetch starts together with the boot redirect
    issue_redirect(PC_BOOT);
    req_i = 1'b1;
    run_cycles(60);
    // low memory holds the all-zero compressed parcels at 0xC and 0xE
    branch_target_i = 32'h0000_0004;
    issue_redirect(PC_JUMP);
    run_cycles(60);
    for (int n = 0; n < 40; n++) begin
      random_redirect();
      run_cycles(40 + take_bits(5));
    end
    // stop fetching and wait for the bus to drain
    step_cycle();
    req_i = 1'b0;
    step_cycle();
    while (if_busy_o) begin
      step_cycle();
    end
    run_cycles(4);
    if (u_ifu_top.u_chk.err_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "checker reported %0d failures", u_ifu_top.u_chk.err_cnt);
    end
  end

endmodule

//--- ifu_top.f
+incdir+hw
hw/ifu_pkg.sv
hw/ifu_pc_select.sv
hw/ifu_fetch_buffer.sv
hw/ifu_id_reg.sv
hw/ifu_pc_check.sv
hw/ifu_top.sv
testbench/ifu_tb_clk.sv
testbench/ifu_top_chk.sv
testbench/ifu_tb.sv

//--- Bender.yml
package:
  name: ifu

sources:
  - include_dirs:
      - hw
    files:
      - hw/ifu_pkg.sv
      - hw/ifu_pc_select.sv
      - hw/ifu_fetch_buffer.sv
      - hw/ifu_id_reg.sv
      - hw/ifu_pc_check.sv
      - hw/ifu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/ifu_tb_clk.sv
      - testbench/ifu_top_chk.sv
      - testbench/ifu_tb.sv
